//--- stage_cfg.svh
`ifndef STAGE_CFG_SVH
`define STAGE_CFG_SVH

// datapath and address width
`define XLEN 32

// byte lanes per data word
`define BE_W 4

// lane offset taken from the low address bits
`define LANE_W 2

`endif

//--- pipe_pkg.sv
`include "stage_cfg.svh"

package pipe_pkg;

    // rv32i funct3 encodings for loads
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_width_e;

    // rv32i funct3 encodings for stores
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_width_e;

    typedef enum logic [1:0] {
        fwd_alu_out    = 2'b00,
        fwd_br_en_zext = 2'b01,
        fwd_u_imm      = 2'b10
    } exe_fwd_sel_e;

    typedef enum logic {
        mar_pc  = 1'b0,
        mar_alu = 1'b1
    } mar_sel_e;

    typedef enum logic {
        mem_fwd_rdata = 1'b0, // data cache read data
        mem_fwd_exe   = 1'b1  // result carried from execute
    } mem_fwd_sel_e;

    // execute to memory stage contents
    typedef struct packed {
        logic [`XLEN-1:0] exe_fwd_data;
        logic [`XLEN-1:0] addr;         // lane aligned for half and byte
        logic [`XLEN-1:0] wdata;
        logic [`BE_W-1:0] be;
        logic             rd;
        logic             wr;
        logic             trap;
        mem_fwd_sel_e     mem_fwd_sel;
    } ex_mem_pkt_t;

    // memory to writeback stage contents
    typedef struct packed {
        logic [`XLEN-1:0] mem_fwd_data;
    } mem_wb_pkt_t;

endpackage

//--- ex_mem_calc.sv
`timescale 1ns/1ps
`include "stage_cfg.svh"

module ex_mem_calc
    import pipe_pkg::*;
(
    input  logic             ex_mem_ld_i,
    input  logic             ex_mem_flush_i,
    input  logic [`XLEN-1:0] alu_out_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] u_imm_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    input  logic             br_en_i,
    input  exe_fwd_sel_e     exe_fwd_sel_i,
    input  mar_sel_e         mar_sel_i,
    input  logic             mem_read_i,
    input  logic             mem_write_i,
    input  load_width_e      load_width_i,
    input  store_width_e     store_width_i,
    input  mem_fwd_sel_e     mem_fwd_sel_i,
    output logic             ex_mem_en_o,
    output logic             ex_mem_valid_o,
    output ex_mem_pkt_t      ex_mem_pkt_o
);

    logic [`XLEN-1:0]   fwd_data;
    logic [`XLEN-1:0]   mar_addr;
    logic [`XLEN-1:0]   aligned_addr;
    logic [`XLEN-1:0]   mem_addr;
    logic [`LANE_W-1:0] lane;
    logic [`BE_W-1:0]   half_mask;
    logic [`BE_W-1:0]   byte_mask;
    logic [`BE_W-1:0]   byte_en;
    logic               trap;

    // flush wins over load, but the register still has to clock
    assign ex_mem_en_o    = ex_mem_ld_i | ex_mem_flush_i;
    assign ex_mem_valid_o = ex_mem_ld_i & ~ex_mem_flush_i;

    always_comb begin : exe_fwd_mux
        case (exe_fwd_sel_i)
            fwd_br_en_zext: fwd_data = {{(`XLEN-1){1'b0}}, br_en_i};
            fwd_u_imm:      fwd_data = u_imm_i;
            default:        fwd_data = alu_out_i;
        endcase
    end

    assign mar_addr     = (mar_sel_i == mar_pc) ? pc_i : alu_out_i;
    assign lane         = mar_addr[`LANE_W-1:0];
    assign aligned_addr = {mar_addr[`XLEN-1:`LANE_W], {`LANE_W{1'b0}}};
    assign half_mask    = {{(`BE_W-2){1'b0}}, 2'b11} << lane;
    assign byte_mask    = {{(`BE_W-1){1'b0}}, 1'b1} << lane;

    always_comb begin : calc_addr
        byte_en  = '0;
        mem_addr = mar_addr;
        trap     = 1'b0;
        if (mem_read_i) begin
            case (load_width_i)
                lw: byte_en = '1;
                lh, lhu: begin
                    byte_en  = half_mask;
                    mem_addr = aligned_addr;
                end
                lb, lbu: begin
                    byte_en  = byte_mask;
                    mem_addr = aligned_addr;
                end
                default: trap = 1'b1; // unknown funct3 leaves the mask zero
            endcase
        end else if (mem_write_i) begin
            case (store_width_i)
                sw: byte_en = '1;
                sh: begin
                    byte_en  = half_mask;
                    mem_addr = aligned_addr;
                end
                sb: begin
                    byte_en  = byte_mask;
                    mem_addr = aligned_addr;
                end
                default: trap = 1'b1;
            endcase
        end
    end

    always_comb begin : pack_out
        ex_mem_pkt_o.exe_fwd_data = fwd_data;
        ex_mem_pkt_o.addr         = mem_addr;
        ex_mem_pkt_o.wdata        = rs2_data_i;
        ex_mem_pkt_o.be           = byte_en;
        ex_mem_pkt_o.rd           = mem_read_i;
        ex_mem_pkt_o.wr           = mem_write_i & ~mem_read_i; // read has priority
        ex_mem_pkt_o.trap         = trap;
        ex_mem_pkt_o.mem_fwd_sel  = mem_fwd_sel_i;
    end

endmodule : ex_mem_calc

//--- pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk or posedge rst) begin : valid_reg
        if (rst) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin : data_reg
        if (rst) begin
            data_o <= '0;
        end else if (load_i) begin
            data_o <= data_i;
        end
    end

endmodule : pipe_reg

//--- mem_wb_calc.sv
`timescale 1ns/1ps
`include "stage_cfg.svh"

module mem_wb_calc
    import pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  mem_fwd_sel_e     mem_fwd_sel_i,
    input  logic [`XLEN-1:0] exe_fwd_data_i,
    input  logic [`XLEN-1:0] mem_rdata_i,
    input  logic             wb_fwd_ld_i,
    input  mem_wb_pkt_t      mem_wb_pkt_i,
    output mem_wb_pkt_t      mem_wb_pkt_o,
    output logic [`XLEN-1:0] wb_fwd_data_o
);

    // picks what the memory stage forwards back
    always_comb begin : mem_fwd_mux
        if (mem_fwd_sel_i == mem_fwd_rdata) begin
            mem_wb_pkt_o.mem_fwd_data = mem_rdata_i;
        end else begin
            mem_wb_pkt_o.mem_fwd_data = exe_fwd_data_i;
        end
    end

    // writeback forward hold
    always_ff @(posedge clk or posedge rst) begin : wb_fwd_reg
        if (rst) begin
            wb_fwd_data_o <= '0;
        end else if (wb_fwd_ld_i) begin
            wb_fwd_data_o <= mem_wb_pkt_i.mem_fwd_data;
        end
    end

endmodule : mem_wb_calc

//--- stage_regs_top.sv
`timescale 1ns/1ps
`include "stage_cfg.svh"

module stage_regs_top
    import pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             ex_mem_ld_i,
    input  logic             ex_mem_flush_i,
    input  logic [`XLEN-1:0] alu_out_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] u_imm_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    input  logic             br_en_i,
    input  exe_fwd_sel_e     exe_fwd_sel_i,
    input  mar_sel_e         mar_sel_i,
    input  logic             mem_read_i,
    input  logic             mem_write_i,
    input  load_width_e      load_width_i,
    input  store_width_e     store_width_i,
    input  mem_fwd_sel_e     mem_fwd_sel_i,
    input  logic             mem_wb_ld_i,
    input  logic [`XLEN-1:0] mem_rdata_i,
    input  logic             wb_fwd_ld_i,
    output logic [`XLEN-1:0] exe_fwd_data_o,
    output logic [`XLEN-1:0] mem_addr_o,
    output logic [`XLEN-1:0] mem_wdata_o,
    output logic [`BE_W-1:0] mem_be_o,
    output logic             mem_read_o,
    output logic             mem_write_o,
    output logic             trap_o,
    output logic             ex_mem_valid_o,
    output logic [`XLEN-1:0] mem_fwd_data_o,
    output logic             mem_wb_valid_o,
    output logic [`XLEN-1:0] wb_fwd_data_o
);

    logic        ex_mem_en;
    logic        ex_mem_vin;
    ex_mem_pkt_t ex_mem_d;
    ex_mem_pkt_t ex_mem_q;
    mem_wb_pkt_t mem_wb_d;
    mem_wb_pkt_t mem_wb_q;

    ex_mem_calc u_ex_mem_calc (
        .ex_mem_ld_i    (ex_mem_ld_i),
        .ex_mem_flush_i (ex_mem_flush_i),
        .alu_out_i      (alu_out_i),
        .pc_i           (pc_i),
        .u_imm_i        (u_imm_i),
        .rs2_data_i     (rs2_data_i),
        .br_en_i        (br_en_i),
        .exe_fwd_sel_i  (exe_fwd_sel_i),
        .mar_sel_i      (mar_sel_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .load_width_i   (load_width_i),
        .store_width_i  (store_width_i),
        .mem_fwd_sel_i  (mem_fwd_sel_i),
        .ex_mem_en_o    (ex_mem_en),
        .ex_mem_valid_o (ex_mem_vin),
        .ex_mem_pkt_o   (ex_mem_d)
    );

    pipe_reg #(.payload_t(ex_mem_pkt_t)) u_ex_mem_reg (
        .clk     (clk),
        .rst     (rst),
        .load_i  (ex_mem_en),
        .valid_i (ex_mem_vin),
        .data_i  (ex_mem_d),
        .valid_o (ex_mem_valid_o),
        .data_o  (ex_mem_q)
    );

    mem_wb_calc u_mem_wb_calc (
        .clk            (clk),
        .rst            (rst),
        .mem_fwd_sel_i  (ex_mem_q.mem_fwd_sel),
        .exe_fwd_data_i (ex_mem_q.exe_fwd_data),
        .mem_rdata_i    (mem_rdata_i),
        .wb_fwd_ld_i    (wb_fwd_ld_i),
        .mem_wb_pkt_i   (mem_wb_q),
        .mem_wb_pkt_o   (mem_wb_d),
        .wb_fwd_data_o  (wb_fwd_data_o)
    );

    // valid follows the ex-mem stage
    pipe_reg #(.payload_t(mem_wb_pkt_t)) u_mem_wb_reg (
        .clk     (clk),
        .rst     (rst),
        .load_i  (mem_wb_ld_i),
        .valid_i (ex_mem_valid_o),
        .data_i  (mem_wb_d),
        .valid_o (mem_wb_valid_o),
        .data_o  (mem_wb_q)
    );

    assign exe_fwd_data_o = ex_mem_q.exe_fwd_data;
    assign mem_addr_o     = ex_mem_q.addr;
    assign mem_wdata_o    = ex_mem_q.wdata;
    assign mem_be_o       = ex_mem_q.be;
    assign mem_read_o     = ex_mem_q.rd;
    assign mem_write_o    = ex_mem_q.wr;
    assign trap_o         = ex_mem_q.trap;
    assign mem_fwd_data_o = mem_wb_q.mem_fwd_data;

endmodule : stage_regs_top

//--- stage_regs_sva.sv
`timescale 1ns/1ps
`include "stage_cfg.svh"

module stage_regs_sva
    import pipe_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             flush_i,
    input logic             ex_valid_i,
    input logic             wb_valid_i,
    input logic             rd_i,
    input logic             wr_i,
    input logic             trap_i,
    input logic [`BE_W-1:0] be_i,
    input logic [`XLEN-1:0] addr_i
);

    trap_no_lanes: assert property (@(posedge clk) disable iff (rst) trap_i |-> be_i == '0)
        else $error("trap with byte lanes enabled");

    flush_kills_valid: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !ex_valid_i)
        else $error("valid still high after flush");

    // partial accesses sit on a lane aligned address
    part_aligned: assert property (@(posedge clk) disable iff (rst)
        (rd_i || wr_i) && !trap_i && be_i != '1 |-> addr_i[`LANE_W-1:0] == '0)
        else $error("half or byte access with unaligned address");

    reset_clears_valid: assert property (@(posedge clk) rst |-> !ex_valid_i && !wb_valid_i)
        else $error("valid high during reset");

endmodule : stage_regs_sva

bind stage_regs_top stage_regs_sva u_stage_regs_sva (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (ex_mem_flush_i),
    .ex_valid_i (ex_mem_valid_o),
    .wb_valid_i (mem_wb_valid_o),
    .rd_i       (mem_read_o),
    .wr_i       (mem_write_o),
    .trap_i     (trap_o),
    .be_i       (mem_be_o),
    .addr_i     (mem_addr_o)
);

//--- tb_stage_regs.sv
`timescale 1ns/1ps
`include "stage_cfg.svh"

module tb_stage_regs
    import pipe_pkg::*;
();

    localparam int TIMEOUT_CYC = 400; // tests need about 165 cycles

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    logic             ex_mem_ld_i = 1'b0, ex_mem_flush_i = 1'b0, br_en_i = 1'b0;
    logic             mem_read_i = 1'b0, mem_write_i = 1'b0;
    logic             mem_wb_ld_i = 1'b0, wb_fwd_ld_i = 1'b0;
    logic [`XLEN-1:0] alu_out_i = '0, pc_i = '0, u_imm_i = '0;
    logic [`XLEN-1:0] rs2_data_i = '0, mem_rdata_i = '0;
    exe_fwd_sel_e     exe_fwd_sel_i = fwd_alu_out;
    mar_sel_e         mar_sel_i = mar_pc;
    load_width_e      load_width_i = lw;
    store_width_e     store_width_i = sw;
    mem_fwd_sel_e     mem_fwd_sel_i = mem_fwd_rdata;
    logic [`XLEN-1:0] exe_fwd_data_o, mem_addr_o, mem_wdata_o, mem_fwd_data_o, wb_fwd_data_o;
    logic [`BE_W-1:0] mem_be_o;
    logic             mem_read_o, mem_write_o, trap_o, ex_mem_valid_o, mem_wb_valid_o;
    int               errors = 0;
    int               checks = 0;
    int               cycle_cnt = 0;

    initial begin
        forever #5 clk = ~clk;
    end

    stage_regs_top u_stage_regs_top (.*);

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic cmp_word(input string name, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic cmp_be(input string name, input logic [`BE_W-1:0] exp,
                          input logic [`BE_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic cmp_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic test_reset_state();
        cmp_bit("ex_mem_valid_o", 1'b0, ex_mem_valid_o);
        cmp_bit("mem_wb_valid_o", 1'b0, mem_wb_valid_o);
        cmp_bit("mem_read_o", 1'b0, mem_read_o);
        cmp_bit("mem_write_o", 1'b0, mem_write_o);
        cmp_bit("trap_o", 1'b0, trap_o);
        cmp_be("mem_be_o", '0, mem_be_o);
        cmp_word("exe_fwd_data_o", '0, exe_fwd_data_o);
        cmp_word("mem_addr_o", '0, mem_addr_o);
        cmp_word("mem_wdata_o", '0, mem_wdata_o);
        cmp_word("mem_fwd_data_o", '0, mem_fwd_data_o);
        cmp_word("wb_fwd_data_o", '0, wb_fwd_data_o);
    endtask

    task automatic fwd_case(input exe_fwd_sel_e sel, input logic br);
        logic [`XLEN-1:0] exp;
        alu_out_i = $urandom;
        u_imm_i = $urandom;
        br_en_i = br;
        exe_fwd_sel_i = sel;
        ex_mem_ld_i = 1'b1;
        case (sel)
            fwd_alu_out:    exp = alu_out_i;
            fwd_br_en_zext: exp = {{(`XLEN-1){1'b0}}, br};
            default:        exp = u_imm_i;
        endcase
        tick();
        cmp_word("exe_fwd_data_o", exp, exe_fwd_data_o);
    endtask

    // one access per cycle with lanes from the rv32i funct3 width rules
    task automatic mem_access(input logic rd, input logic wr, input logic [2:0] code,
                              input mar_sel_e src, input logic [`LANE_W-1:0] lane);
        logic [`XLEN-1:0] base;
        logic [`XLEN-1:0] exp_addr;
        logic [`XLEN-1:0] wdata;
        logic [`BE_W-1:0] be_exp;
        logic             bad;
        base = $urandom;
        base[`LANE_W-1:0] = lane;
        wdata = $urandom;
        pc_i = (src == mar_pc) ? base : $urandom;
        alu_out_i = (src == mar_alu) ? base : $urandom;
        rs2_data_i = wdata;
        mar_sel_i = src;
        mem_read_i = rd;
        mem_write_i = wr;
        load_width_i = load_width_e'(code);
        store_width_i = store_width_e'(code);
        ex_mem_ld_i = 1'b1;
        if (rd) begin
            bad = (code[1:0] == 2'b11) || (code[2:1] == 2'b11);
        end else begin
            bad = wr && (code[2] || code[1:0] == 2'b11);
        end
        be_exp = '0;
        if (!bad && (rd || wr)) begin
            case (code[1:0])
                2'b00:   be_exp = 4'b0001 << lane;
                2'b01:   be_exp = 4'b0011 << lane;
                default: be_exp = 4'b1111;
            endcase
        end
        exp_addr = base;
        if (code[1:0] != 2'b10) exp_addr[`LANE_W-1:0] = '0;
        tick();
        cmp_be("mem_be_o", be_exp, mem_be_o);
        cmp_bit("trap_o", bad, trap_o);
        cmp_bit("mem_read_o", rd, mem_read_o);
        cmp_bit("mem_write_o", wr & ~rd, mem_write_o);
        cmp_word("mem_wdata_o", wdata, mem_wdata_o);
        if (!bad && (rd || wr)) cmp_word("mem_addr_o", exp_addr, mem_addr_o);
    endtask

    task automatic test_masks();
        for (int rw = 0; rw < 2; rw++) begin
            for (int src = 0; src < 2; src++) begin
                for (int code = 0; code < 8; code++) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        mem_access(rw == 0, rw == 1, code[2:0], mar_sel_e'(src[0]),
                                   lane[`LANE_W-1:0]);
                    end
                end
            end
        end
        mem_access(1'b1, 1'b1, 3'b010, mar_alu, 2'b01); // read beats write
        mem_access(1'b0, 1'b0, 3'b000, mar_pc, 2'b10);
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        ex_mem_ld_i = 1'b0;
    endtask

    task automatic test_hold_flush();
        logic [`XLEN-1:0] held;
        fwd_case(fwd_u_imm, 1'b0);
        held = u_imm_i;
        ex_mem_ld_i = 1'b0;
        repeat (3) begin
            u_imm_i = $urandom;
            alu_out_i = $urandom;
            tick();
            cmp_word("exe_fwd_data_o", held, exe_fwd_data_o);
            cmp_bit("ex_mem_valid_o", 1'b1, ex_mem_valid_o);
        end
        ex_mem_ld_i = 1'b1;
        ex_mem_flush_i = 1'b1; // flush together with load
        tick();
        cmp_bit("ex_mem_valid_o", 1'b0, ex_mem_valid_o);
        ex_mem_flush_i = 1'b0;
        fwd_case(fwd_alu_out, 1'b0);
        cmp_bit("ex_mem_valid_o", 1'b1, ex_mem_valid_o);
        ex_mem_ld_i = 1'b0;
        ex_mem_flush_i = 1'b1;
        tick();
        cmp_bit("ex_mem_valid_o", 1'b0, ex_mem_valid_o);
        ex_mem_flush_i = 1'b0;
        tick();
        cmp_bit("ex_mem_valid_o", 1'b0, ex_mem_valid_o);
    endtask

    task automatic test_mem_wb();
        logic [`XLEN-1:0] rdata;
        logic [`XLEN-1:0] exe_val;
        mem_fwd_sel_i = mem_fwd_rdata;
        fwd_case(fwd_alu_out, 1'b0);
        ex_mem_ld_i = 1'b0;
        mem_fwd_sel_i = mem_fwd_exe; // only the captured select counts
        rdata = $urandom;
        mem_rdata_i = rdata;
        mem_wb_ld_i = 1'b1;
        tick();
        cmp_word("mem_fwd_data_o", rdata, mem_fwd_data_o);
        cmp_bit("mem_wb_valid_o", 1'b1, mem_wb_valid_o);
        mem_wb_ld_i = 1'b0;
        wb_fwd_ld_i = 1'b1;
        tick();
        cmp_word("wb_fwd_data_o", rdata, wb_fwd_data_o);
        wb_fwd_ld_i = 1'b0;
        mem_fwd_sel_i = mem_fwd_exe;
        fwd_case(fwd_alu_out, 1'b0);
        exe_val = alu_out_i;
        ex_mem_ld_i = 1'b0;
        mem_fwd_sel_i = mem_fwd_rdata;
        mem_rdata_i = $urandom;
        mem_wb_ld_i = 1'b1;
        tick();
        cmp_word("mem_fwd_data_o", exe_val, mem_fwd_data_o);
        cmp_word("wb_fwd_data_o", rdata, wb_fwd_data_o); // held without a load
        mem_wb_ld_i = 1'b0;
        wb_fwd_ld_i = 1'b1;
        tick();
        wb_fwd_ld_i = 1'b0;
        repeat (2) tick();
        cmp_word("wb_fwd_data_o", exe_val, wb_fwd_data_o);
        ex_mem_flush_i = 1'b1;
        tick();
        ex_mem_flush_i = 1'b0;
        mem_wb_ld_i = 1'b1;
        tick();
        cmp_bit("mem_wb_valid_o", 1'b0, mem_wb_valid_o);
        mem_wb_ld_i = 1'b0;
    endtask

    task automatic test_reset_midrun();
        mem_read_i = 1'b1;
        load_width_i = lw;
        mem_fwd_sel_i = mem_fwd_exe;
        fwd_case(fwd_u_imm, 1'b1);
        ex_mem_ld_i = 1'b0;
        mem_read_i = 1'b0;
        mem_wb_ld_i = 1'b1;
        tick();
        mem_wb_ld_i = 1'b0;
        wb_fwd_ld_i = 1'b1;
        tick();
        wb_fwd_ld_i = 1'b0;
        cmp_bit("mem_wb_valid_o", 1'b1, mem_wb_valid_o);
        cmp_bit("mem_read_o", 1'b1, mem_read_o);
        rst = 1'b1; // both stages full
        repeat (2) tick();
        rst = 1'b0;
        test_reset_state();
    endtask

    initial begin
        void'($urandom(33));
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        fwd_case(fwd_alu_out, 1'b1);
        fwd_case(fwd_br_en_zext, 1'b1);
        fwd_case(fwd_br_en_zext, 1'b0);
        fwd_case(fwd_u_imm, 1'b1);
        test_masks();
        test_hold_flush();
        test_mem_wb();
        test_reset_midrun();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYC);
        $display(">>> FAIL");
        $finish;
    end

endmodule : tb_stage_regs

//--- flist.f
+incdir+.
pipe_pkg.sv
ex_mem_calc.sv
pipe_reg.sv
mem_wb_calc.sv
stage_regs_top.sv
stage_regs_sva.sv
tb_stage_regs.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_stage_regs

status=0
./obj_dir/Vtb_stage_regs > sim.log 2>&1 || status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
